/* slink_axi_addr_bridge.f */
src/slink_pkg.sv
src/axi_addr_pkg.sv
src/slink_pkt_if.sv
src/slink_addr_packer.sv
src/slink_tx_serializer.sv
src/slink_rx_deserializer.sv
src/slink_addr_unpacker.sv
src/slink_axi_addr_bridge.sv
testbench/tb_slink_axi_addr_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# Compile with Verilator and run; a $fatal in the testbench gives a failing status
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 \
  -f slink_axi_addr_bridge.f \
  --top-module tb_slink_axi_addr_bridge \
  -o tb_sim \
  && ./obj_dir/tb_sim \
  || exit 1

/* testbench/slink_addr_vectors.txt */
// mode_chan_outcome_request: mode 0 normal 1 crc 2 bad_id 3 hold_ready 4 disabled, f ends
// chan 0 AW 1 AR 2 both, outcome 0 lost 1 delivered 2 dropped, request is the 70-bit field word
0_0_1_1a5c3f0e1_b7d49620c
0_1_1_0fedcba98_7654321a5
0_2_1_2c0ffee00_1a2b3c4d5
1_0_0_3deadbeef_000011117
1_1_0_0aaaa5555_5aa5a55a3
2_0_2_1cafef00d_123456789
2_1_2_2badc0de0_fedcba987
3_0_1_000001000_0f0f0f0f0
3_1_1_3ffffffff_fffffffff
4_0_1_112233445_566778899
4_1_1_2a1b2c3d4_e5f607182
0_2_1_012345670_89abcdef0
0_0_1_000000000_000000000
f_0_0_000000000_000000000

/* testbench/tb_slink_axi_addr_bridge.sv */
`timescale 1ns/1ps

module tb_slink_axi_addr_bridge;

  localparam logic [3:0]  MODE_CRC      = 4'd1;
  localparam logic [3:0]  MODE_BAD_ID   = 4'd2;
  localparam logic [3:0]  MODE_HOLD     = 4'd3;
  localparam logic [3:0]  MODE_DISABLED = 4'd4;
  localparam logic [3:0]  MODE_END      = 4'hf;
  localparam logic [3:0]  EXP_DELIVERED = 4'd1;
  localparam logic [3:0]  EXP_DROPPED   = 4'd2;
  localparam logic [7:0]  BAD_ID        = 8'h5a;
  localparam logic [15:0] PKT_BYTES     = 16'd9;
  localparam int          TIMEOUT       = 300;

  logic        axi_clk;
  logic        rst_n;
  logic        enable;
  logic [31:0] tgt_awaddr, tgt_araddr, ini_awaddr, ini_araddr;
  logic [7:0]  tgt_awid, tgt_arid, ini_awid, ini_arid;
  logic [7:0]  tgt_awlen, tgt_arlen, ini_awlen, ini_arlen;
  logic [3:0]  tgt_awregion, tgt_arregion, ini_awregion, ini_arregion;
  logic [3:0]  tgt_awqos, tgt_arqos, ini_awqos, ini_arqos;
  logic [3:0]  tgt_awcache, tgt_arcache, ini_awcache, ini_arcache;
  logic [2:0]  tgt_awprot, tgt_arprot, ini_awprot, ini_arprot;
  logic [2:0]  tgt_awsize, tgt_arsize, ini_awsize, ini_arsize;
  logic [1:0]  tgt_awlock, tgt_arlock, ini_awlock, ini_arlock;
  logic [1:0]  tgt_awburst, tgt_arburst, ini_awburst, ini_arburst;
  logic        tgt_awvalid, tgt_awready, tgt_arvalid, tgt_arready;
  logic        ini_awvalid, ini_awready, ini_arvalid, ini_arready;
  logic        tx_sop, tx_advance, rx_sop, rx_valid, rx_crc_corrupted, rx_drop;
  logic [7:0]  tx_data_id, rx_data_id;
  logic [15:0] tx_word_count, rx_word_count;
  logic [31:0] tx_app_data, rx_app_data;

  logic [69:0] aw_req, ar_req, ini_aw_flat, ini_ar_flat;
  logic [83:0] vec_mem [0:31];
  logic [69:0] aw_got [$];
  logic [69:0] ar_got [$];
  logic [31:0] lfsr = 32'h9627_b34d;
  logic [3:0]  link_mode;
  logic        hold_ready;
  int          word_idx;
  int          link_pkts;
  int          drop_cnt;

  slink_axi_addr_bridge #(
    .AW_DATA_ID (8'h20),
    .AR_DATA_ID (8'h21)
  ) i_slink_axi_addr_bridge (.*);

  // Field order runs from addr down to id as in the AXI address struct
  assign {tgt_awaddr, tgt_awregion, tgt_awqos, tgt_awprot, tgt_awcache,
          tgt_awlock, tgt_awburst, tgt_awsize, tgt_awlen, tgt_awid} = aw_req;
  assign {tgt_araddr, tgt_arregion, tgt_arqos, tgt_arprot, tgt_arcache,
          tgt_arlock, tgt_arburst, tgt_arsize, tgt_arlen, tgt_arid} = ar_req;
  assign ini_aw_flat = {ini_awaddr, ini_awregion, ini_awqos, ini_awprot, ini_awcache,
                        ini_awlock, ini_awburst, ini_awsize, ini_awlen, ini_awid};
  assign ini_ar_flat = {ini_araddr, ini_arregion, ini_arqos, ini_arprot, ini_arcache,
                        ini_arlock, ini_arburst, ini_arsize, ini_arlen, ini_arid};

  initial begin
    axi_clk = 1'b0;
    forever #5 axi_clk = ~axi_clk;
  end

  // Galois LFSR stepped once per bit
  function automatic logic lfsr_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  task automatic compare(string name, logic [69:0] expected, logic [69:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "first mismatch ends the run");
    end
  endtask

  task automatic wait_cycle(string what, inout int waited);
    @(negedge axi_clk);
    waited++;
    if (waited > TIMEOUT) begin
      $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
      $display("Verification failed");
      $fatal(1, "wait loop ran out of cycles");
    end
  endtask

  //--------------------------------------------------
  // Link loopback and AXI initiator sink
  //--------------------------------------------------
  initial begin : link_model
    int reset_wait;
    tx_advance       = 1'b0;
    rx_sop           = 1'b0;
    rx_valid         = 1'b0;
    rx_crc_corrupted = 1'b0;
    rx_data_id       = 8'h00;
    rx_word_count    = 16'h0000;
    rx_app_data      = 32'h0;
    ini_awready      = 1'b0;
    ini_arready      = 1'b0;
    reset_wait       = 0;
    while (rst_n !== 1'b1) begin
      wait_cycle("reset release", reset_wait);
    end
    forever begin
      @(posedge axi_clk);
      #1;
      rx_valid         = 1'b0;
      rx_sop           = 1'b0;
      rx_crc_corrupted = 1'b0;
      tx_advance       = 1'b0;
      if (rx_drop) begin
        drop_cnt++;
      end
      if (tx_sop || word_idx != 0) begin
        tx_advance = lfsr_bit() | lfsr_bit();
        if (tx_advance) begin
          if (tx_sop) begin
            compare("link word count", 70'(PKT_BYTES), 70'(tx_word_count));
          end
          rx_valid         = 1'b1;
          rx_sop           = tx_sop;
          rx_data_id       = (link_mode == MODE_BAD_ID) ? BAD_ID : tx_data_id;
          rx_word_count    = tx_word_count;
          rx_app_data      = tx_app_data;
          rx_crc_corrupted = (link_mode == MODE_CRC) && (word_idx == 2);
          word_idx         = (word_idx == 2) ? 0 : word_idx + 1;
          if (word_idx == 0) begin
            link_pkts++;
          end
        end
      end
      ini_awready = hold_ready ? 1'b0 : lfsr_bit();
      ini_arready = hold_ready ? 1'b0 : lfsr_bit();
      if (ini_awvalid && ini_awready) begin
        aw_got.push_back(ini_aw_flat);
      end
      if (ini_arvalid && ini_arready) begin
        ar_got.push_back(ini_ar_flat);
      end
    end
  end

  //--------------------------------------------------
  // Driver and checker
  //--------------------------------------------------
  task automatic send_request(string name);
    int   waited;
    logic aw_fire;
    logic ar_fire;
    waited = 0;
    while (tgt_awvalid || tgt_arvalid) begin
      wait_cycle({name, " target handshake"}, waited);
      aw_fire = tgt_awvalid && tgt_awready;
      ar_fire = tgt_arvalid && tgt_arready;
      @(posedge axi_clk);
      #1;
      if (aw_fire) begin
        tgt_awvalid = 1'b0;
      end
      if (ar_fire) begin
        tgt_arvalid = 1'b0;
      end
    end
  endtask

  task automatic expect_delivery(string name, logic is_ar, logic [69:0] req);
    int          waited;
    logic [69:0] got;
    waited = 0;
    while ((is_ar ? ar_got.size() : aw_got.size()) == 0) begin
      wait_cycle({name, " delivery"}, waited);
    end
    got = is_ar ? ar_got.pop_front() : aw_got.pop_front();
    compare(name, req, got);
  endtask

  task automatic run_item(int n, logic [83:0] v);
    string       name;
    logic [3:0]  chan;
    logic [3:0]  outcome;
    logic [69:0] req;
    int          drops0;
    int          pkts0;
    int          waited;
    name    = $sformatf("item %0d", n);
    chan    = v[79:76];
    outcome = v[75:72];
    req     = v[69:0];
    drops0  = drop_cnt;
    pkts0   = link_pkts;
    @(negedge axi_clk);
    link_mode  = v[83:80];
    hold_ready = v[83:80] == MODE_HOLD;
    @(posedge axi_clk);
    #1;
    // The two channels always carry different words
    aw_req      = (chan == 4'd1) ? ~req : req;
    ar_req      = (chan == 4'd1) ? req : ~req;
    tgt_awvalid = chan != 4'd1;
    tgt_arvalid = chan != 4'd0;
    if (link_mode == MODE_DISABLED) begin
      enable = 1'b0;
      repeat (10) begin
        @(negedge axi_clk);
        compare({name, " tgt ready while disabled"}, 70'd0, 70'({tgt_awready, tgt_arready}));
        compare({name, " tx_sop while disabled"}, 70'd0, 70'(tx_sop));
      end
      @(posedge axi_clk);
      #1;
      enable = 1'b1;
    end
    send_request(name);
    if (hold_ready) begin
      waited = 0;
      while (!(chan == 4'd1 ? ini_arvalid : ini_awvalid)) begin
        wait_cycle({name, " ini valid"}, waited);
      end
      repeat (20) begin
        @(negedge axi_clk);
        compare({name, " ini valid held"}, 70'd1, 70'(chan == 4'd1 ? ini_arvalid : ini_awvalid));
        compare({name, " held request"}, req, chan == 4'd1 ? ini_ar_flat : ini_aw_flat);
      end
      hold_ready = 1'b0;
    end
    if (outcome == EXP_DELIVERED) begin
      if (chan != 4'd1) begin
        expect_delivery({name, " AW"}, 1'b0, aw_req);
      end
      if (chan != 4'd0) begin
        expect_delivery({name, " AR"}, 1'b1, ar_req);
      end
    end else begin
      waited = 0;
      while (link_pkts == pkts0 || (outcome == EXP_DROPPED && drop_cnt == drops0)) begin
        wait_cycle({name, " link packet end or rx_drop"}, waited);
      end
      repeat (8) begin
        @(negedge axi_clk);
        compare({name, " ini valid after loss"}, 70'd0, 70'({ini_awvalid, ini_arvalid}));
      end
    end
    compare({name, " rx_drop pulses"}, 70'(outcome == EXP_DROPPED), 70'(drop_cnt - drops0));
    compare({name, " extra deliveries"}, 70'd0, 70'(aw_got.size() + ar_got.size()));
  endtask

  initial begin : main
    rst_n       = 1'b0;
    enable      = 1'b1;
    tgt_awvalid = 1'b0;
    tgt_arvalid = 1'b0;
    aw_req      = 70'd0;
    ar_req      = 70'd0;
    link_mode   = 4'd0;
    hold_ready  = 1'b0;
    $readmemh("testbench/slink_addr_vectors.txt", vec_mem);
    repeat (16) @(posedge axi_clk);
    #1;
    rst_n = 1'b1;
    for (int n = 0; n < 32 && vec_mem[n][83:80] != MODE_END; n++) begin
      run_item(n, vec_mem[n]);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

/* src/slink_axi_addr_bridge.sv */
`timescale 1ns/1ps

module slink_axi_addr_bridge
  import slink_pkg::*;
  import axi_addr_pkg::*;
#(
  parameter logic [7:0] AW_DATA_ID = 8'h20,
  parameter logic [7:0] AR_DATA_ID = 8'h21
) (
  input  logic                      axi_clk,
  input  logic                      rst_n,
  input  logic                      enable,

  //--------------------------------------------------
  // AXI target and initiator
  //--------------------------------------------------
  input  logic [AXI_ID_WIDTH-1:0]   tgt_awid,
  input  logic [AXI_ADDR_WIDTH-1:0] tgt_awaddr,
  input  logic [7:0]                tgt_awlen,
  input  logic [2:0]                tgt_awsize, tgt_awprot,
  input  logic [1:0]                tgt_awburst, tgt_awlock,
  input  logic [3:0]                tgt_awcache, tgt_awqos, tgt_awregion,
  input  logic                      tgt_awvalid,
  output logic                      tgt_awready,

  input  logic [AXI_ID_WIDTH-1:0]   tgt_arid,
  input  logic [AXI_ADDR_WIDTH-1:0] tgt_araddr,
  input  logic [7:0]                tgt_arlen,
  input  logic [2:0]                tgt_arsize, tgt_arprot,
  input  logic [1:0]                tgt_arburst, tgt_arlock,
  input  logic [3:0]                tgt_arcache, tgt_arqos, tgt_arregion,
  input  logic                      tgt_arvalid,
  output logic                      tgt_arready,

  output logic [AXI_ID_WIDTH-1:0]   ini_awid,
  output logic [AXI_ADDR_WIDTH-1:0] ini_awaddr,
  output logic [7:0]                ini_awlen,
  output logic [2:0]                ini_awsize, ini_awprot,
  output logic [1:0]                ini_awburst, ini_awlock,
  output logic [3:0]                ini_awcache, ini_awqos, ini_awregion,
  output logic                      ini_awvalid,
  input  logic                      ini_awready,

  output logic [AXI_ID_WIDTH-1:0]   ini_arid,
  output logic [AXI_ADDR_WIDTH-1:0] ini_araddr,
  output logic [7:0]                ini_arlen,
  output logic [2:0]                ini_arsize, ini_arprot,
  output logic [1:0]                ini_arburst, ini_arlock,
  output logic [3:0]                ini_arcache, ini_arqos, ini_arregion,
  output logic                      ini_arvalid,
  input  logic                      ini_arready,

  //--------------------------------------------------
  // Link layer
  //--------------------------------------------------
  output logic                      tx_sop,
  output logic [7:0]                tx_data_id,
  output logic [15:0]               tx_word_count,
  output slink_word_t               tx_app_data,
  input  logic                      tx_advance,

  input  logic                      rx_sop,
  input  logic [7:0]                rx_data_id,
  input  logic [15:0]               rx_word_count,
  input  slink_word_t               rx_app_data,
  input  logic                      rx_valid,
  input  logic                      rx_crc_corrupted,

  output logic                      rx_drop
);

  addr_chan_t tgt_aw;
  addr_chan_t tgt_ar;
  addr_chan_t ini_aw;
  addr_chan_t ini_ar;
  logic       rx_pkt_strobe;
  logic [7:0] rx_pkt_id;
  addr_chan_u rx_pkt;

  slink_pkt_if pkt_link ();

  assign tgt_aw = {tgt_awaddr, tgt_awregion, tgt_awqos, tgt_awprot, tgt_awcache,
                   tgt_awlock, tgt_awburst, tgt_awsize, tgt_awlen, tgt_awid};
  assign tgt_ar = {tgt_araddr, tgt_arregion, tgt_arqos, tgt_arprot, tgt_arcache,
                   tgt_arlock, tgt_arburst, tgt_arsize, tgt_arlen, tgt_arid};

  assign {ini_awaddr, ini_awregion, ini_awqos, ini_awprot, ini_awcache,
          ini_awlock, ini_awburst, ini_awsize, ini_awlen, ini_awid} = ini_aw;
  assign {ini_araddr, ini_arregion, ini_arqos, ini_arprot, ini_arcache,
          ini_arlock, ini_arburst, ini_arsize, ini_arlen, ini_arid} = ini_ar;

  // Stage ports share their names with the signals here
  slink_addr_packer #(
    .AW_DATA_ID (AW_DATA_ID),
    .AR_DATA_ID (AR_DATA_ID)
  ) u_packer (
    .pkt (pkt_link),
    .*
  );

  slink_tx_serializer u_serializer (
    .pkt (pkt_link),
    .*
  );

  slink_rx_deserializer u_deserializer (
    .*
  );

  slink_addr_unpacker #(
    .AW_DATA_ID (AW_DATA_ID),
    .AR_DATA_ID (AR_DATA_ID)
  ) u_unpacker (
    .*
  );

endmodule

/* src/slink_addr_unpacker.sv */
`timescale 1ns/1ps

module slink_addr_unpacker
  import axi_addr_pkg::*;
#(
  parameter logic [7:0] AW_DATA_ID = 8'h20,
  parameter logic [7:0] AR_DATA_ID = 8'h21
) (
  input  logic       axi_clk,
  input  logic       rst_n,

  input  logic       rx_pkt_strobe,
  input  logic [7:0] rx_pkt_id,
  input  addr_chan_u rx_pkt,

  output logic       ini_awvalid,
  output addr_chan_t ini_aw,
  input  logic       ini_awready,

  output logic       ini_arvalid,
  output addr_chan_t ini_ar,
  input  logic       ini_arready,

  output logic       rx_drop
);

  // Slot 0 is AW, slot 1 is AR
  logic [1:0] slot_full_q;
  logic [1:0] slot_ready;
  logic [1:0] slot_hit;
  logic [1:0] slot_take;
  logic       drop_q;
  addr_chan_t slot_q [2];

  assign slot_ready = {ini_arready, ini_awready};
  assign slot_hit   = {rx_pkt_id == AR_DATA_ID, rx_pkt_id == AW_DATA_ID};
  // A slot draining this cycle can take the next packet
  assign slot_take  = {2{rx_pkt_strobe}} & slot_hit & ~(slot_full_q & ~slot_ready);

  always_ff @(posedge axi_clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_full_q <= 2'b00;
      drop_q      <= 1'b0;
    end else begin
      slot_full_q <= (slot_full_q & ~slot_ready) | slot_take;
      drop_q      <= rx_pkt_strobe & ~|slot_take;
    end
  end

  always_ff @(posedge axi_clk) begin
    for (int i = 0; i < 2; i++) begin
      if (slot_take[i]) begin
        slot_q[i] <= rx_pkt.fields;
      end
    end
  end

  assign ini_awvalid = slot_full_q[0];
  assign ini_aw      = slot_q[0];
  assign ini_arvalid = slot_full_q[1];
  assign ini_ar      = slot_q[1];
  assign rx_drop     = drop_q;

endmodule

/* src/slink_rx_deserializer.sv */
`timescale 1ns/1ps

module slink_rx_deserializer
  import slink_pkg::*;
  import axi_addr_pkg::*;
(
  input  logic        axi_clk,
  input  logic        rst_n,

  input  logic        rx_sop,
  input  logic [7:0]  rx_data_id,
  input  logic [15:0] rx_word_count,
  input  slink_word_t rx_app_data,
  input  logic        rx_valid,
  input  logic        rx_crc_corrupted,

  output logic        rx_pkt_strobe,
  output logic [7:0]  rx_pkt_id,
  output addr_chan_u  rx_pkt
);

  localparam int PKT_W = $bits(slink_pkt_t);

  logic       active_q;
  logic [1:0] cnt_q;
  logic       wc_ok_q;
  logic       strobe_q;
  logic [7:0] id_q;
  slink_pkt_t buf_q;
  logic       last;

  assign last = active_q & ~rx_sop & (cnt_q == 2'(ADDR_PKT_WORDS - 1));

  always_ff @(posedge axi_clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      cnt_q    <= 2'd0;
      wc_ok_q  <= 1'b0;
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= 1'b0;
      if (rx_valid) begin
        if (rx_sop) begin
          // A new sop throws away any partial packet
          active_q <= 1'b1;
          cnt_q    <= 2'd1;
          wc_ok_q  <= rx_word_count == ADDR_PKT_WC;
        end else if (last) begin
          active_q <= 1'b0;
          cnt_q    <= 2'd0;
          strobe_q <= wc_ok_q & ~rx_crc_corrupted;
        end else if (active_q) begin
          cnt_q    <= cnt_q + 2'd1;
        end
      end
    end
  end

  // Shift in from the top so word 0 ends up in the low bits
  always_ff @(posedge axi_clk) begin
    if (rx_valid & rx_sop) begin
      id_q <= rx_data_id;
    end
    if (rx_valid & (rx_sop | active_q)) begin
      buf_q <= {rx_app_data, buf_q[PKT_W-1:SLINK_WORD_WIDTH]};
    end
  end

  assign rx_pkt_strobe = strobe_q;
  assign rx_pkt_id     = id_q;
  assign rx_pkt.flat   = buf_q[ADDR_CHAN_WIDTH-1:0];

endmodule

/* src/slink_tx_serializer.sv */
`timescale 1ns/1ps

module slink_tx_serializer
  import slink_pkg::*;
(
  input  logic            axi_clk,
  input  logic            rst_n,

  slink_pkt_if.serializer pkt,

  output logic            tx_sop,
  output logic [7:0]      tx_data_id,
  output logic [15:0]     tx_word_count,
  output slink_word_t     tx_app_data,
  input  logic            tx_advance
);

  logic       busy_q;
  logic [1:0] idx_q;
  logic [7:0] id_q;
  slink_pkt_t pkt_q;
  logic       load;
  logic       step;
  logic       last;

  assign pkt.ready = ~busy_q;

  assign load = pkt.valid & ~busy_q;
  // Advance only counts while a packet is held
  assign step = busy_q & tx_advance;
  assign last = idx_q == 2'(ADDR_PKT_WORDS - 1);

  always_ff @(posedge axi_clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      idx_q  <= 2'd0;
    end else if (load) begin
      busy_q <= 1'b1;
      idx_q  <= 2'd0;
    end else if (step) begin
      if (last) begin
        busy_q <= 1'b0;
        idx_q  <= 2'd0;
      end else begin
        idx_q  <= idx_q + 2'd1;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (load) begin
      id_q  <= pkt.data_id;
      pkt_q <= slink_pkt_t'(pkt.pkt.flat);
    end
  end

  // Words go out low first
  assign tx_sop        = busy_q & (idx_q == 2'd0);
  assign tx_data_id    = id_q;
  assign tx_word_count = ADDR_PKT_WC;
  assign tx_app_data   = pkt_q[idx_q*SLINK_WORD_WIDTH +: SLINK_WORD_WIDTH];

endmodule

/* src/slink_addr_packer.sv */
`timescale 1ns/1ps

module slink_addr_packer
  import axi_addr_pkg::*;
#(
  parameter logic [7:0] AW_DATA_ID = 8'h20,
  parameter logic [7:0] AR_DATA_ID = 8'h21
) (
  input  logic        axi_clk,
  input  logic        rst_n,
  input  logic        enable,

  input  logic        tgt_awvalid,
  input  addr_chan_t  tgt_aw,
  output logic        tgt_awready,

  input  logic        tgt_arvalid,
  input  addr_chan_t  tgt_ar,
  output logic        tgt_arready,

  slink_pkt_if.packer pkt
);

  logic       full_q;
  logic [7:0] id_q;
  addr_chan_u pkt_q;
  logic       accept;
  logic       aw_take;
  logic       ar_take;

  // Single packet register that stays closed while disabled
  assign accept      = enable & ~full_q;
  assign tgt_awready = accept;
  // AW wins a tie
  assign tgt_arready = accept & ~tgt_awvalid;

  assign aw_take = tgt_awvalid & tgt_awready;
  assign ar_take = tgt_arvalid & tgt_arready;

  always_ff @(posedge axi_clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (aw_take | ar_take) begin
      full_q <= 1'b1;
    end else if (full_q & pkt.ready) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (aw_take) begin
      id_q         <= AW_DATA_ID;
      pkt_q.fields <= tgt_aw;
    end else if (ar_take) begin
      id_q         <= AR_DATA_ID;
      pkt_q.fields <= tgt_ar;
    end
  end

  assign pkt.valid   = full_q;
  assign pkt.data_id = id_q;
  assign pkt.pkt     = pkt_q;

endmodule

/* src/slink_pkt_if.sv */
`timescale 1ns/1ps

interface slink_pkt_if
  import axi_addr_pkg::*;
();

  logic       valid;
  logic       ready;
  logic [7:0] data_id;
  addr_chan_u pkt;

  modport packer (
    output valid,
    output data_id,
    output pkt,
    input  ready
  );

  modport serializer (
    input  valid,
    input  data_id,
    input  pkt,
    output ready
  );

endinterface

/* src/axi_addr_pkg.sv */
package axi_addr_pkg;

  localparam int AXI_ADDR_WIDTH = 32;
  localparam int AXI_ID_WIDTH   = 8;

  // Same order as the link payload with id in the low byte
  typedef struct packed {
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [3:0]                region;
    logic [3:0]                qos;
    logic [2:0]                prot;
    logic [3:0]                cache;
    logic [1:0]                lock;
    logic [1:0]                burst;
    logic [2:0]                size;
    logic [7:0]                len;
    logic [AXI_ID_WIDTH-1:0]   id;
  } addr_chan_t;

  localparam int ADDR_CHAN_WIDTH = $bits(addr_chan_t);

  // Field view for the AXI side, flat view for slicing into link words
  typedef union packed {
    addr_chan_t                 fields;
    logic [ADDR_CHAN_WIDTH-1:0] flat;
  } addr_chan_u;

endpackage

/* src/slink_pkg.sv */
package slink_pkg;

  //--------------------------------------------------
  // Link application layer
  //--------------------------------------------------
  localparam int SLINK_WORD_WIDTH = 32;

  typedef logic [SLINK_WORD_WIDTH-1:0] slink_word_t;

  //--------------------------------------------------
  // Address packet framing
  //--------------------------------------------------
  // 70 payload bits rounded up to whole bytes
  localparam logic [15:0] ADDR_PKT_WC    = 16'd9;
  localparam int          ADDR_PKT_WORDS = 3;

  // Payload padded out to whole link words
  typedef logic [ADDR_PKT_WORDS*SLINK_WORD_WIDTH-1:0] slink_pkt_t;

endpackage
